//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing -j 0
TOP      = ppu_tb
FILELIST = ppu.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Simulation finished: PASS$$" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- logic/palette_rgb.sv
//**********************************************************
// system colour table and registered RGB output
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module palette_rgb
    import ppu_timing_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic [5:0] i_index,
    input  logic       i_visible,
    output logic [7:0] o_red,
    output logic [7:0] o_green,
    output logic [7:0] o_blue
);

    // 64 colours as 0xRRGGBB
    localparam logic [23:0] SYS_COLOURS [64] = '{
        24'h7C7C7C, 24'h0000FC, 24'h0000BC, 24'h4428BC,
        24'h940084, 24'hA80020, 24'hA81000, 24'h881400,
        24'h503000, 24'h007800, 24'h006800, 24'h005800,
        24'h004058, 24'h000000, 24'h000000, 24'h000000,
        24'hBCBCBC, 24'h0078F8, 24'h0058F8, 24'h6844FC,
        24'hD800CC, 24'hE40058, 24'hF83800, 24'hE45C10,
        24'hAC7C00, 24'h00B800, 24'h00A800, 24'h00A844,
        24'h008888, 24'h000000, 24'h000000, 24'h000000,
        24'hF8F8F8, 24'h3CBCFC, 24'h6888FC, 24'h9878F8,
        24'hF878F8, 24'hF85898, 24'hF87858, 24'hFCA044,
        24'hF8B800, 24'hB8F818, 24'h58D854, 24'h58F898,
        24'h00E8D8, 24'h787878, 24'h000000, 24'h000000,
        24'hFFFFFF, 24'hA4E4FC, 24'hB8B8F8, 24'hD8B8F8,
        24'hF8B8F8, 24'hF8A4C0, 24'hF0D0B0, 24'hFCE0A8,
        24'hF8D878, 24'hD8F878, 24'hB8F8B8, 24'hB8F8D8,
        24'h00FCFC, 24'hF8D8F8, 24'h000000, 24'h000000
    };

    logic [23:0] rgb_q;

    // one cycle behind the raster, black outside the picture
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            rgb_q <= 24'h000000;
        else if (i_visible)
            rgb_q <= SYS_COLOURS[i_index];
        else
            rgb_q <= 24'h000000;
    end

    assign o_red   = rgb_q[23:16];
    assign o_green = rgb_q[15:8];
    assign o_blue  = rgb_q[7:0];

endmodule

`default_nettype wire

//--- logic/ppu_registers.sv
//**********************************************************
// CPU register block, OAM, palette RAM and PPUDATA access
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module ppu_registers
    import ppu_regs_pkg::*;
    import ppu_timing_pkg::*;
(
    input  logic           i_clk,
    input  logic           i_reset_n,
    input  logic           i_cs_n,
    input  rs_t            i_rs,
    input  logic           i_rw,
    input  logic [7:0]     i_data,
    output logic [7:0]     o_data,
    output logic           o_int_n,
    input  logic           i_vblank_start,
    input  logic           i_vblank_end,
    output logic [5:0]     o_bg_index,
    video_bus_if.requester vbus
);

    logic [7:0]  ppuctrl;
    logic [7:0]  ppumask;
    logic [7:0]  oamaddr;
    logic [7:0]  scroll_x;
    logic [7:0]  scroll_y;
    logic [15:0] ppuaddr;
    logic        write_toggle;
    logic        vblank_flag;
    logic        rd_capture;
    logic [7:0]  read_buffer;

    logic [7:0]  oam [256];
    logic [7:0]  palette [32];

    logic        cpu_rd;
    logic        cpu_wr;
    logic        status_rd;
    logic        data_access;
    logic        in_palette;
    logic [15:0] addr_step;

    assign cpu_rd      = !i_cs_n && (i_rw == RW_READ);
    assign cpu_wr      = !i_cs_n && (i_rw == RW_WRITE);
    assign status_rd   = cpu_rd && (i_rs == PPUSTATUS);
    assign data_access = !i_cs_n && (i_rs == PPUDATA);
    // 0x3F00 and up within the 14-bit space is palette RAM
    assign in_palette  = (ppuaddr[PPU_ADDR_W-1:0] >= PALETTE_BASE);
    assign addr_step   = ppuctrl[CTRL_INC32_BIT] ? 16'd32 : 16'd1;

    // read data appears in the same cycle as the access
    always_comb
    begin
        o_data = 8'h00;
        if (cpu_rd)
        begin
            case (i_rs)
                PPUSTATUS: o_data = {vblank_flag, 7'b0000000};
                OAMDATA:   o_data = oam[oamaddr];
                PPUDATA:   o_data = in_palette ? palette[ppuaddr[4:0]] : read_buffer;
                default:   o_data = 8'h00;
            endcase
        end
    end

    // control registers and the shared write toggle
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            ppuctrl      <= 8'h00;
            ppumask      <= 8'h00;
            oamaddr      <= 8'h00;
            scroll_x     <= 8'h00;
            scroll_y     <= 8'h00;
            ppuaddr      <= 16'h0000;
            write_toggle <= 1'b0;
        end
        else if (status_rd)
        begin
            write_toggle <= 1'b0;
        end
        else if (data_access)
        begin
            // reads and writes both step the address
            ppuaddr <= ppuaddr + addr_step;
        end
        else if (cpu_wr)
        begin
            case (i_rs)
                PPUCTRL: ppuctrl <= i_data;
                PPUMASK: ppumask <= i_data;
                OAMADDR: oamaddr <= i_data;
                OAMDATA: oamaddr <= oamaddr + 8'd1;
                PPUSCROLL:
                begin
                    if (write_toggle)
                        scroll_y <= i_data;
                    else
                        scroll_x <= i_data;
                    write_toggle <= !write_toggle;
                end
                PPUADDR:
                begin
                    // high byte first
                    if (write_toggle)
                        ppuaddr[7:0] <= i_data;
                    else
                        ppuaddr[15:8] <= i_data;
                    write_toggle <= !write_toggle;
                end
                default:
                begin
                end
            endcase
        end
    end

    // OAM and palette storage
    always_ff @(posedge i_clk)
    begin
        if (cpu_wr && (i_rs == OAMDATA))
            oam[oamaddr] <= i_data;
        if (cpu_wr && data_access && in_palette)
            palette[ppuaddr[4:0]] <= i_data;
    end

    // a status read wins over the raster events
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            vblank_flag <= 1'b0;
        else if (status_rd)
            vblank_flag <= 1'b0;
        else if (i_vblank_start)
            vblank_flag <= 1'b1;
        else if (i_vblank_end)
            vblank_flag <= 1'b0;
    end

    // video bus requests
    // the strobe goes low the cycle after the CPU access
    // and read data reaches the buffer one cycle later
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            vbus.rd_n   <= 1'b1;
            vbus.we_n   <= 1'b1;
            rd_capture  <= 1'b0;
            read_buffer <= 8'h00;
        end
        else
        begin
            vbus.rd_n  <= !(data_access && cpu_rd && !in_palette);
            vbus.we_n  <= !(data_access && cpu_wr && !in_palette);
            rd_capture <= !vbus.rd_n;
            if (rd_capture)
                read_buffer <= vbus.rdata;
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (data_access)
        begin
            vbus.addr  <= ppuaddr[PPU_ADDR_W-1:0];
            vbus.wdata <= i_data;
        end
    end

    assign o_int_n    = !(vblank_flag && ppuctrl[CTRL_NMI_EN_BIT]);
    // background colour comes from palette entry 0
    assign o_bg_index = palette[0][5:0];

endmodule

`default_nettype wire

//--- logic/ppu_regs_pkg.sv
//**********************************************************
// register select codes, bus levels, control bits and
// address ranges of the CPU-visible PPU registers
//**********************************************************
`default_nettype none

package ppu_regs_pkg;

    // register select on the CPU port
    typedef enum logic [2:0]
    {
        PPUCTRL   = 3'd0,
        PPUMASK   = 3'd1,
        PPUSTATUS = 3'd2,
        OAMADDR   = 3'd3,
        OAMDATA   = 3'd4,
        PPUSCROLL = 3'd5,
        PPUADDR   = 3'd6,
        PPUDATA   = 3'd7
    } rs_t;

    // levels of the read/write line
    localparam logic RW_READ  = 1'b1;
    localparam logic RW_WRITE = 1'b0;

    // PPUCTRL bit positions
    localparam int CTRL_INC32_BIT  = 2;
    localparam int CTRL_NMI_EN_BIT = 7;

    // video address space
    localparam int PPU_ADDR_W = 14;
    localparam logic [PPU_ADDR_W-1:0] PALETTE_BASE = 14'h3F00;

endpackage

`default_nettype wire

//--- logic/ppu_timing.sv
//**********************************************************
// raster counter, visible area and vblank strobes
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module ppu_timing
    import ppu_timing_pkg::*;
(
    input  logic       i_clk,
    input  logic       i_reset_n,
    output logic [8:0] o_x,
    output logic [8:0] o_y,
    output logic       o_visible,
    output logic       o_vblank_start,
    output logic       o_vblank_end
);

    logic line_end;

    assign line_end = (o_x == SCREEN_WIDTH - 9'd1);

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_x <= 9'd0;
            o_y <= 9'd0;
        end
        else if (line_end)
        begin
            o_x <= 9'd0;
            o_y <= (o_y == SCREEN_HEIGHT - 9'd1) ? 9'd0 : o_y + 9'd1;
        end
        else
        begin
            o_x <= o_x + 9'd1;
        end
    end

    assign o_visible = (o_x < VISIBLE_WIDTH) && (o_y < VISIBLE_HEIGHT);

    // high in the last cycle of the line before, so the flag
    // changes at the edge that starts x=0 of the event line
    assign o_vblank_start = line_end && (o_y == VBLANK_START_LINE - 9'd1);
    assign o_vblank_end   = line_end && (o_y == VBLANK_END_LINE - 9'd1);

endmodule

`default_nettype wire

//--- logic/ppu_timing_pkg.sv
//**********************************************************
// raster dimensions and vblank lines
//**********************************************************
`default_nettype none

package ppu_timing_pkg;

    // full raster including blanking
    localparam logic [8:0] SCREEN_WIDTH  = 9'd341;
    localparam logic [8:0] SCREEN_HEIGHT = 9'd262;

    // visible picture area
    localparam logic [8:0] VISIBLE_WIDTH  = 9'd256;
    localparam logic [8:0] VISIBLE_HEIGHT = 9'd240;

    // vblank flag set on the first, cleared on the second
    localparam logic [8:0] VBLANK_START_LINE = 9'd241;
    localparam logic [8:0] VBLANK_END_LINE   = 9'd261;

endpackage

`default_nettype wire

//--- logic/ppu_top.sv
//**********************************************************
// PPU top level, CPU port and video output
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module ppu_top
    import ppu_regs_pkg::*;
#(
    parameter int VRAM_ADDR_W = 11
)
(
    input  logic       i_clk,
    input  logic       i_reset_n,
    input  logic       i_cs_n,
    input  rs_t        i_rs,
    input  logic       i_rw,
    input  logic [7:0] i_data,
    output logic [7:0] o_data,
    output logic       o_int_n,
    output logic [7:0] o_video_red,
    output logic [7:0] o_video_green,
    output logic [7:0] o_video_blue,
    output logic [8:0] o_video_x,
    output logic [8:0] o_video_y,
    output logic       o_video_visible
);

    logic       vblank_start;
    logic       vblank_end;
    logic [5:0] bg_index;

    video_bus_if vbus ();

    ppu_registers u_registers (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .i_cs_n         (i_cs_n),
        .i_rs           (i_rs),
        .i_rw           (i_rw),
        .i_data         (i_data),
        .o_data         (o_data),
        .o_int_n        (o_int_n),
        .i_vblank_start (vblank_start),
        .i_vblank_end   (vblank_end),
        .o_bg_index     (bg_index),
        .vbus           (vbus.requester)
    );

    ppu_timing u_timing (
        .i_clk          (i_clk),
        .i_reset_n      (i_reset_n),
        .o_x            (o_video_x),
        .o_y            (o_video_y),
        .o_visible      (o_video_visible),
        .o_vblank_start (vblank_start),
        .o_vblank_end   (vblank_end)
    );

    palette_rgb u_palette (
        .i_clk     (i_clk),
        .i_reset_n (i_reset_n),
        .i_index   (bg_index),
        .i_visible (o_video_visible),
        .o_red     (o_video_red),
        .o_green   (o_video_green),
        .o_blue    (o_video_blue)
    );

    video_ram #(
        .VRAM_ADDR_W (VRAM_ADDR_W)
    ) u_vram (
        .i_clk (i_clk),
        .vbus  (vbus.memory)
    );

endmodule

`default_nettype wire

//--- logic/video_bus_if.sv
//**********************************************************
// internal video memory bus with requester and memory views
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

interface video_bus_if
    import ppu_regs_pkg::*;
();

    // strobes are active low, one cycle per access
    logic                  rd_n;
    logic                  we_n;
    logic [PPU_ADDR_W-1:0] addr;
    logic [7:0]            wdata;
    // valid the cycle after a read strobe
    logic [7:0]            rdata;

    modport requester (output rd_n, output we_n, output addr, output wdata, input rdata);

    modport memory (input rd_n, input we_n, input addr, input wdata, output rdata);

endinterface

`default_nettype wire

//--- logic/video_ram.sv
//**********************************************************
// mirrored video memory on the internal video bus
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module video_ram
    import ppu_regs_pkg::*;
#(
    parameter int VRAM_ADDR_W = 11
)
(
    input  logic        i_clk,
    video_bus_if.memory vbus
);

    logic [7:0] mem [2**VRAM_ADDR_W];

    logic [VRAM_ADDR_W-1:0] mem_addr;
    logic                   in_range;

    // upper address bits are ignored, so the RAM repeats through
    // the whole space below the palette
    assign mem_addr = vbus.addr[VRAM_ADDR_W-1:0];
    assign in_range = (vbus.addr < PALETTE_BASE);

    always_ff @(posedge i_clk)
    begin
        if (!vbus.we_n && in_range)
            mem[mem_addr] <= vbus.wdata;
        if (!vbus.rd_n)
            vbus.rdata <= mem[mem_addr];
    end

endmodule

`default_nettype wire

//--- ppu.f
logic/ppu_regs_pkg.sv
logic/ppu_timing_pkg.sv
logic/video_bus_if.sv
logic/ppu_registers.sv
logic/ppu_timing.sv
logic/palette_rgb.sv
logic/video_ram.sv
logic/ppu_top.sv
verification/ppu_tb.sv

//--- verification/ppu_tb.sv
//**********************************************************
// PPU testbench with CPU access tasks, reference model and
// checks of registers, memories, vblank NMI and video output
//**********************************************************
`timescale 1ns/10ps
`default_nettype none

module ppu_tb
    import ppu_regs_pkg::*;
    import ppu_timing_pkg::*;
();

    localparam int VRAM_ADDR_W  = 11;
    localparam int FRAME_CYCLES = int'(SCREEN_WIDTH) * int'(SCREEN_HEIGHT);
    localparam int WAIT_LIMIT   = 2 * FRAME_CYCLES;

    logic       clk;
    logic       reset_n;
    logic       cs_n;
    rs_t        rs;
    logic       rw;
    logic [7:0] wr_data;
    logic [7:0] rd_data;
    logic       int_n;
    logic [7:0] video_red;
    logic [7:0] video_green;
    logic [7:0] video_blue;
    logic [8:0] video_x;
    logic [8:0] video_y;
    logic       video_visible;

    int check_count;
    int error_count;
    int timeout_count;

    // reads waiting for the compare process
    string      name_q [$];
    logic [7:0] act_q [$];
    logic [7:0] exp_q [$];

    // reference model state
    logic [7:0]  m_ctrl;
    logic [15:0] m_addr;
    logic        m_toggle;
    logic [7:0]  m_buffer;
    logic [7:0]  m_oamaddr;
    logic        m_vblank;
    logic [7:0]  m_oam [256];
    logic [7:0]  m_pal [32];
    logic [7:0]  m_vram [2**VRAM_ADDR_W];

    ppu_top #(
        .VRAM_ADDR_W (VRAM_ADDR_W)
    ) u_dut (
        .i_clk           (clk),
        .i_reset_n       (reset_n),
        .i_cs_n          (cs_n),
        .i_rs            (rs),
        .i_rw            (rw),
        .i_data          (wr_data),
        .o_data          (rd_data),
        .o_int_n         (int_n),
        .o_video_red     (video_red),
        .o_video_green   (video_green),
        .o_video_blue    (video_blue),
        .o_video_x       (video_x),
        .o_video_y       (video_y),
        .o_video_visible (video_visible)
    );

    always #5 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected)
        begin
            $display("Mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            error_count++;
        end
    endtask

    // compares every read that the CPU tasks have queued
    always @(posedge clk)
    begin
        while (exp_q.size() > 0)
            check_value(name_q.pop_front(), 32'(act_q.pop_front()), 32'(exp_q.pop_front()));
    end

    // applies one CPU access to the model and returns the expected read data
    function automatic logic [7:0] model_access(input rs_t sel, input logic dir,
                                                input logic [7:0] data);
        logic [7:0]  result;
        logic [13:0] a;
        logic [15:0] step;
        result = 8'h00;
        a      = m_addr[13:0];
        step   = m_ctrl[CTRL_INC32_BIT] ? 16'd32 : 16'd1;
        if (dir == RW_READ)
        begin
            case (sel)
                PPUSTATUS:
                begin
                    result   = {m_vblank, 7'b0000000};
                    m_vblank = 1'b0;
                    m_toggle = 1'b0;
                end
                OAMDATA: result = m_oam[m_oamaddr];
                PPUDATA:
                begin
                    if (a >= PALETTE_BASE)
                        result = m_pal[a[4:0]];
                    else
                    begin
                        // the fetched byte shows up on the next read
                        result   = m_buffer;
                        m_buffer = m_vram[a[VRAM_ADDR_W-1:0]];
                    end
                    m_addr = m_addr + step;
                end
                default: result = 8'h00;
            endcase
        end
        else
        begin
            case (sel)
                PPUCTRL: m_ctrl = data;
                OAMADDR: m_oamaddr = data;
                OAMDATA:
                begin
                    m_oam[m_oamaddr] = data;
                    m_oamaddr        = m_oamaddr + 8'd1;
                end
                PPUSCROLL: m_toggle = !m_toggle;
                PPUADDR:
                begin
                    if (m_toggle)
                        m_addr[7:0] = data;
                    else
                        m_addr[15:8] = data;
                    m_toggle = !m_toggle;
                end
                PPUDATA:
                begin
                    if (a >= PALETTE_BASE)
                        m_pal[a[4:0]] = data;
                    else
                        m_vram[a[VRAM_ADDR_W-1:0]] = data;
                    m_addr = m_addr + step;
                end
                default:
                begin
                end
            endcase
        end
        return result;
    endfunction

    function automatic logic [7:0] fill_byte(input logic [15:0] a);
        return a[7:0] + {a[10:8], 5'h13};
    endfunction

    task automatic cpu_write(input rs_t sel, input logic [7:0] data);
        @(posedge clk);
        cs_n    <= 1'b0;
        rs      <= sel;
        rw      <= RW_WRITE;
        wr_data <= data;
        void'(model_access(sel, RW_WRITE, data));
        @(posedge clk);
        cs_n <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    task automatic cpu_read(input rs_t sel, input string name);
        logic [7:0] actual;
        logic [7:0] expected;
        @(posedge clk);
        cs_n <= 1'b0;
        rs   <= sel;
        rw   <= RW_READ;
        @(negedge clk);
        actual   = rd_data;
        expected = model_access(sel, RW_READ, 8'h00);
        name_q.push_back(name);
        act_q.push_back(actual);
        exp_q.push_back(expected);
        @(posedge clk);
        cs_n <= 1'b1;
        repeat (2) @(posedge clk);
    endtask

    task automatic set_addr(input logic [15:0] a);
        cpu_write(PPUADDR, a[15:8]);
        cpu_write(PPUADDR, a[7:0]);
    endtask

    task automatic wait_line(input logic [8:0] line, input logic want_equal);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (((video_y == line) != want_equal) && (cycles < WAIT_LIMIT))
        begin
            @(negedge clk);
            cycles++;
        end
        if ((video_y == line) != want_equal)
        begin
            $display("Timeout: raster line %0d was never %s", line,
                     want_equal ? "reached" : "left");
            timeout_count++;
        end
    endtask

    // o_int_n must stay high until the given line begins
    task automatic hold_int_high_until(input logic [8:0] line);
        int cycles;
        cycles = 0;
        while ((video_y != line) && (cycles < WAIT_LIMIT))
        begin
            check_value("o_int_n", 32'(int_n), 32'd1);
            @(negedge clk);
            cycles++;
        end
        if (video_y != line)
        begin
            $display("Timeout: vblank did not end at raster line %0d", line);
            timeout_count++;
        end
    endtask

    task automatic vram_round(input logic step32);
        logic [15:0] base;
        int          i;
        base = 16'($urandom_range(0, 32'h2BFF));
        cpu_write(PPUCTRL, step32 ? 8'h04 : 8'h00);
        set_addr(base);
        for (i = 0; i < 8; i++)
            cpu_write(PPUDATA, 8'($urandom));
        set_addr(base);
        for (i = 0; i < 8; i++)
            cpu_read(PPUDATA, "o_data ppudata");
        // same bytes through the mirror one RAM size higher
        set_addr(base + (16'd1 << VRAM_ADDR_W));
        for (i = 0; i < 8; i++)
            cpu_read(PPUDATA, "o_data ppudata mirror");
    endtask

    task automatic fill_and_verify_vram();
        int i;
        cpu_write(PPUCTRL, 8'h00);
        set_addr(16'h0000);
        for (i = 0; i < 2**VRAM_ADDR_W; i++)
            cpu_write(PPUDATA, fill_byte(16'(i)));
        for (i = 0; i < 4; i++)
            vram_round(i >= 2);
        cpu_write(PPUCTRL, 8'h00);
    endtask

    task automatic palette_direct_access();
        logic [15:0] a;
        int          i;
        for (i = 0; i < 8; i++)
        begin
            a = {8'h3F, 8'($urandom)};
            set_addr(a);
            cpu_write(PPUDATA, 8'($urandom));
            set_addr(a);
            cpu_read(PPUDATA, "o_data palette");
            // bits above the low 5 select the same entry
            set_addr({8'h3F, a[7:0] ^ 8'h20});
            cpu_read(PPUDATA, "o_data palette alias");
        end
    endtask

    task automatic oam_readback();
        logic [7:0] base;
        int         i;
        base = 8'($urandom);
        cpu_write(OAMADDR, base);
        for (i = 0; i < 6; i++)
            cpu_write(OAMDATA, 8'($urandom));
        for (i = 0; i < 6; i++)
        begin
            cpu_write(OAMADDR, base + 8'(i));
            cpu_read(OAMDATA, "o_data oamdata");
        end
    endtask

    task automatic toggle_reset_by_status();
        set_addr(16'h0123);
        cpu_write(PPUDATA, 8'h5A);
        set_addr(16'h0456);
        cpu_write(PPUDATA, 8'hA5);
        // high byte only, then the status read puts the toggle back
        cpu_write(PPUADDR, 8'h07);
        cpu_read(PPUSTATUS, "o_data ppustatus");
        set_addr(16'h0456);
        cpu_read(PPUDATA, "o_data ppudata stale");
        cpu_read(PPUDATA, "o_data ppudata 0x0456");
    endtask

    task automatic vblank_nmi_frames();
        cpu_write(PPUCTRL, 8'h80);
        wait_line(VBLANK_START_LINE, 1'b1);
        check_value("o_int_n", 32'(int_n), 32'd0);
        m_vblank = 1'b1;
        cpu_read(PPUSTATUS, "o_data ppustatus vblank");
        @(negedge clk);
        check_value("o_int_n", 32'(int_n), 32'd1);
        cpu_read(PPUSTATUS, "o_data ppustatus cleared");
        // next frame with the NMI disabled
        cpu_write(PPUCTRL, 8'h00);
        wait_line(VBLANK_START_LINE, 1'b0);
        wait_line(VBLANK_START_LINE, 1'b1);
        m_vblank = 1'b1;
        hold_int_high_until(VBLANK_END_LINE);
        m_vblank = 1'b0;
        cpu_read(PPUSTATUS, "o_data ppustatus after vblank");
    endtask

    task automatic scan_frame(input logic [23:0] colour);
        logic [8:0] px;
        logic [8:0] py;
        logic [8:0] ex;
        logic [8:0] ey;
        logic       pvis;
        logic       evis;
        int         n;
        @(negedge clk);
        px   = video_x;
        py   = video_y;
        pvis = (px < VISIBLE_WIDTH) && (py < VISIBLE_HEIGHT);
        for (n = 0; n < FRAME_CYCLES; n++)
        begin
            @(negedge clk);
            ex = (px == SCREEN_WIDTH - 9'd1) ? 9'd0 : px + 9'd1;
            ey = py;
            if (px == SCREEN_WIDTH - 9'd1)
                ey = (py == SCREEN_HEIGHT - 9'd1) ? 9'd0 : py + 9'd1;
            evis = (ex < VISIBLE_WIDTH) && (ey < VISIBLE_HEIGHT);
            check_value("o_video_x", 32'(video_x), 32'(ex));
            check_value("o_video_y", 32'(video_y), 32'(ey));
            check_value("o_video_visible", 32'(video_visible), 32'(evis));
            // colour follows the previous cycle's position
            check_value("o_video_rgb", 32'({video_red, video_green, video_blue}),
                        32'(pvis ? colour : 24'h000000));
            px   = ex;
            py   = ey;
            pvis = evis;
        end
    endtask

    task automatic colour_frames();
        set_addr(16'h3F00);
        cpu_write(PPUDATA, 8'h30);
        scan_frame(24'hFFFFFF);
        set_addr(16'h3F00);
        cpu_write(PPUDATA, 8'h0F);
        scan_frame(24'h000000);
    endtask

    initial
    begin
        clk           = 1'b0;
        reset_n      <= 1'b0;
        cs_n         <= 1'b1;
        rs           <= PPUCTRL;
        rw           <= RW_READ;
        wr_data      <= 8'h00;
        check_count   = 0;
        error_count   = 0;
        timeout_count = 0;
        m_ctrl        = 8'h00;
        m_addr        = 16'h0000;
        m_toggle      = 1'b0;
        m_buffer      = 8'h00;
        m_oamaddr     = 8'h00;
        m_vblank      = 1'b0;
        void'($urandom(62));
        repeat (8) @(posedge clk);
        reset_n <= 1'b1;
        @(negedge clk);
        check_value("o_int_n", 32'(int_n), 32'd1);
        check_value("o_data", 32'(rd_data), 32'd0);
        check_value("o_video_x", 32'(video_x), 32'd0);
        check_value("o_video_y", 32'(video_y), 32'd0);
        fill_and_verify_vram();
        palette_direct_access();
        oam_readback();
        toggle_reset_by_status();
        vblank_nmi_frames();
        colour_frames();
        repeat (2) @(posedge clk);
        $display("checks %0d, mismatches %0d, timeouts %0d",
                 check_count, error_count, timeout_count);
        if ((error_count == 0) && (timeout_count == 0))
            $display("Simulation finished: PASS");
        else
            $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
